// File: Makefile
# Verilator build and run of the note game testbench

all: run

obj_dir/Vtb_note_game: note_game_top.f $(shell cat note_game_top.f)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_note_game -f note_game_top.f

run: obj_dir/Vtb_note_game
	./obj_dir/Vtb_note_game | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: note_filter.sv
`timescale 1ns/1ps
`default_nettype none

module note_filter (
    input  logic            clk,
    input  logic            rst,
    input  note_pkg::note_t match,
    output note_pkg::note_t stable_note,
    output logic            note_strobe
);

    import note_pkg::*;

    note_t                 pick;
    note_t                 sel_note;
    logic [w_stable - 1:0] stable_cnt;
    logic                  settled;

    // --------------------------------------------------
    // Lowest note index wins, which is the highest bit

    always_comb begin
        pick = no_note;
        for (int i = 0; i < n_notes; i++) begin
            if (match[i]) begin
                pick = note_t'(1) << i;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_note <= no_note;
        end else begin
            sel_note <= pick;
        end
    end

    // --------------------------------------------------
    // Stability counter

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stable_cnt <= '0;
        end else if (pick == sel_note) begin
            stable_cnt <= stable_cnt + 1'b1;
        end else begin
            stable_cnt <= '0;
        end
    end

    assign settled = &stable_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stable_note <= no_note;
            note_strobe <= 1'b0;
        end else begin
            note_strobe <= 1'b0;
            if (settled) begin
                stable_note <= sel_note;
                // Pulse only on a change to a real note
                note_strobe <= (sel_note != stable_note) && (sel_note != no_note);
            end
        end
    end

    a_stable_onehot : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(stable_note)
    );

    a_strobe_note : assert property (
        @(posedge clk) disable iff (rst)
        note_strobe |-> (stable_note != no_note)
    );

endmodule

`default_nettype wire

// File: note_game_top.f
note_pkg.sv
period_meter.sv
note_matcher.sv
note_filter.sv
segment_encoder.sv
song_checker.sv
note_game_top.sv
tb_note_game.sv

// File: note_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module note_game_top #(
    parameter int clk_hz = 50_000_000
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  logic [note_pkg::w_mic - 1:0]      mic,
    output note_pkg::seg_t                   abcdefgh,
    output logic [note_pkg::w_digit - 1:0]    digit,
    output note_pkg::game_state_t            game_state,
    output logic [note_pkg::w_song_pos - 1:0] song_pos
);

    import note_pkg::*;

    logic [w_period - 1:0] period;
    note_t                 match;
    note_t                 stable_note;
    logic                  note_strobe;

    // --------------------------------------------------
    // Period measurement

    period_meter u_period (
        .clk          (clk),
        .rst          (rst),
        .mic          (mic),
        .period       (period),
        .period_valid ()
    );

    // --------------------------------------------------
    // Match bank, index 0 is C on the top bit

    for (genvar k = 0; k < n_notes; k++) begin : g_match
        note_matcher #(
            .clk_hz   (clk_hz),
            .note_idx (k)
        ) u_matcher (
            .clk    (clk),
            .rst    (rst),
            .period (period),
            .match  (match[n_notes - 1 - k])
        );
    end

    note_filter u_filter (
        .clk         (clk),
        .rst         (rst),
        .match       (match),
        .stable_note (stable_note),
        .note_strobe (note_strobe)
    );

    // --------------------------------------------------
    // Display and game

    segment_encoder u_segment (
        .clk         (clk),
        .rst         (rst),
        .stable_note (stable_note),
        .abcdefgh    (abcdefgh),
        .digit       (digit)
    );

    song_checker u_song (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .stable_note (stable_note),
        .note_strobe (note_strobe),
        .game_state  (game_state),
        .song_pos    (song_pos)
    );

endmodule

`default_nettype wire

// File: note_matcher.sv
`timescale 1ns/1ps
`default_nettype none

module note_matcher #(
    parameter int clk_hz   = 50_000_000,
    parameter int note_idx = 0
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [note_pkg::w_period - 1:0] period,
    output logic                           match
);

    import note_pkg::*;

    // Centre periods in cycles divided by 100, one per octave
    localparam int base_1 = clk_hz / freq_100[note_idx];
    localparam int base_2 = clk_hz / (freq_100[note_idx] * 2);
    localparam int base_4 = clk_hz / (freq_100[note_idx] * 4);

    function automatic logic in_window (
        input logic [w_period - 1:0] p,
        input int                    base
    );
        int p_int;
        p_int     = int'(p);
        in_window = (p_int > base * win_low_pct) && (p_int < base * win_high_pct);
    endfunction

    // --------------------------------------------------
    // Registered match over the three octaves

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            match <= 1'b0;
        end else begin
            // Zero period means no tone at all
            match <= (period != '0)
                   && (in_window(period, base_1)
                   ||  in_window(period, base_2)
                   ||  in_window(period, base_4));
        end
    end

endmodule

`default_nettype wire

// File: note_pkg.sv
`default_nettype none

package note_pkg;

    // --------------------------------------------------
    // Widths

    localparam int w_mic      = 24;
    localparam int w_period   = 16;
    localparam int n_notes    = 12;
    localparam int w_note_idx = 4;
    localparam int w_stable   = 12;
    localparam int w_digit    = 8;
    localparam int w_song_pos = 3;

    // One-hot note, bit 11 is C and bit 0 is B
    typedef logic [n_notes - 1:0] note_t;

    localparam note_t no_note = '0;

    // --------------------------------------------------
    // Note table

    // Frequency times 100, index 0 is C
    localparam int freq_100 [n_notes] = '{
        26163, 27718, 29366, 31113, 32963, 34923,
        36999, 39200, 41530, 44000, 46616, 49388
    };

    // Window bounds in percent of the centre period
    localparam int win_low_pct  = 97;
    localparam int win_high_pct = 103;

    // --------------------------------------------------
    // Seven-segment patterns, abcdefgh

    typedef logic [7:0] seg_t;

    // Only the middle bar
    localparam seg_t seg_none = 8'b0000_0010;

    localparam seg_t seg_table [n_notes] = '{
        8'b1001_1100,  // C
        8'b1001_1101,  // C#
        8'b0111_1010,  // D
        8'b0111_1011,  // D#
        8'b1001_1110,  // E
        8'b1000_1110,  // F
        8'b1000_1111,  // F#
        8'b1011_1100,  // G
        8'b1011_1101,  // G#
        8'b1110_1110,  // A
        8'b1110_1111,  // A#
        8'b0011_1110   // B
    };

    // --------------------------------------------------
    // Song and game

    localparam int song_len = 8;

    // E G D C D E G D
    localparam logic [w_note_idx - 1:0] song [song_len] = '{
        4'd4, 4'd7, 4'd2, 4'd0, 4'd2, 4'd4, 4'd7, 4'd2
    };

    typedef enum logic [1:0] {
        idle,
        playing,
        win,
        fail
    } game_state_t;

    // Note index to its one-hot bit
    function automatic note_t note_of (input logic [w_note_idx - 1:0] idx);
        note_of = note_t'(1) << (n_notes - 1 - idx);
    endfunction

endpackage

`default_nettype wire

// File: period_meter.sv
`timescale 1ns/1ps
`default_nettype none

module period_meter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [note_pkg::w_mic - 1:0]    mic,
    output logic [note_pkg::w_period - 1:0] period,
    output logic                           period_valid
);

    import note_pkg::*;

    logic                  sign_now;
    logic                  sign_prev;
    logic [w_period - 1:0] counter;
    logic                  crossing;
    logic                  saturated;

    // --------------------------------------------------
    // Sign history of the microphone samples

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sign_now  <= 1'b0;
            sign_prev <= 1'b0;
        end else begin
            sign_now  <= mic[w_mic - 1];
            sign_prev <= sign_now;
        end
    end

    // Negative to positive
    assign crossing  = sign_prev & ~sign_now;
    assign saturated = &counter;

    // --------------------------------------------------
    // Cycle counter and period latch

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counter      <= '0;
            period       <= '0;
            period_valid <= 1'b0;
        end else if (crossing) begin
            counter      <= '0;
            period       <= counter;
            period_valid <= (counter != '0);
        end else if (saturated) begin
            // Too long without a crossing, treat as silence
            period       <= '0;
            period_valid <= 1'b0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    a_period_cause : assert property (
        @(posedge clk) disable iff (rst)
        $changed(period) |-> $past(crossing || saturated)
    );

endmodule

`default_nettype wire

// File: segment_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module segment_encoder (
    input  logic                          clk,
    input  logic                          rst,
    input  note_pkg::note_t               stable_note,
    output note_pkg::seg_t                abcdefgh,
    output logic [note_pkg::w_digit - 1:0] digit
);

    import note_pkg::*;

    seg_t pattern;

    // --------------------------------------------------
    // One-hot note to letter

    always_comb begin
        pattern = seg_none;
        for (int k = 0; k < n_notes; k++) begin
            if (stable_note == note_of(w_note_idx'(k))) begin
                pattern = seg_table[k];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            abcdefgh <= '0;
        end else begin
            abcdefgh <= pattern;
        end
    end

    // Rightmost digit only
    assign digit = w_digit'(1);

endmodule

`default_nettype wire

// File: song_checker.sv
`timescale 1ns/1ps
`default_nettype none

module song_checker (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  note_pkg::note_t                  stable_note,
    input  logic                             note_strobe,
    output note_pkg::game_state_t            game_state,
    output logic [note_pkg::w_song_pos - 1:0] song_pos
);

    import note_pkg::*;

    logic  start_sync;
    logic  start_prev;
    logic  start_edge;
    note_t expected;
    logic  last_note;

    // --------------------------------------------------
    // Start key rising edge

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_sync <= 1'b0;
            start_prev <= 1'b0;
            start_edge <= 1'b0;
        end else begin
            start_sync <= start;
            start_prev <= start_sync;
            start_edge <= start_sync & ~start_prev;
        end
    end

    assign expected  = note_of(song[song_pos]);
    assign last_note = (song_pos == w_song_pos'(song_len - 1));

    // --------------------------------------------------
    // Game FSM

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_state <= idle;
            song_pos   <= '0;
        end else begin
            case (game_state)
                idle: begin
                    if (start_edge) begin
                        game_state <= playing;
                        song_pos   <= '0;
                    end
                end
                playing: begin
                    if (start_edge) begin
                        game_state <= idle;
                        song_pos   <= '0;
                    end else if (note_strobe) begin
                        if (stable_note != expected) begin
                            game_state <= fail;
                        end else if (last_note) begin
                            game_state <= win;
                        end else begin
                            song_pos <= song_pos + 1'b1;
                        end
                    end
                end
                default: begin
                    // Win or fail waits for the key
                    if (start_edge) begin
                        game_state <= idle;
                        song_pos   <= '0;
                    end
                end
            endcase
        end
    end

    a_idle_pos : assert property (
        @(posedge clk) disable iff (rst)
        (game_state == idle) |-> (song_pos == '0)
    );

endmodule

`default_nettype wire

// File: tb_note_game.sv
`timescale 1ns/1ps
`default_nettype none

module tb_note_game;

    import note_pkg::*;

    localparam int clk_hz       = 10_000_000;
    localparam int reset_cycles = 3;
    localparam int tone_periods = 3;
    localparam int max_jitter   = 20;
    localparam int silence_len  = 70_000;
    localparam int settle_len   = (1 << w_stable) + 50;
    localparam int press_len    = 4;
    localparam int press_gap    = 10;
    localparam int off_window   = 3000;

    localparam int step_start   = 0;
    localparam int step_tone    = 1;
    localparam int step_silence = 2;

    localparam logic [w_mic - 1:0] mic_high = w_mic'(1000);
    localparam logic [w_mic - 1:0] mic_low  = w_mic'(-1000);

    typedef struct {
        int          kind;
        int          period;
        bit          press;
        game_state_t exp_state;
        int          exp_pos;
    } step_t;

    logic                    clk;
    logic                    rst;
    logic                    start;
    logic [w_mic - 1:0]      mic;
    seg_t                    abcdefgh;
    logic [w_digit - 1:0]    digit;
    game_state_t             game_state;
    logic [w_song_pos - 1:0] song_pos;

    step_t steps [64];
    int    n_steps     = 0;
    int    errors      = 0;
    int    checks      = 0;
    int    cycles      = 0;
    int    cycle_limit = 0;

    note_game_top #(
        .clk_hz (clk_hz)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .mic        (mic),
        .abcdefgh   (abcdefgh),
        .digit      (digit),
        .game_state (game_state),
        .song_pos   (song_pos)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------------------------------------
    // Expected values from the window rule

    function automatic int centre_period(input int k, input int mult);
        centre_period = (clk_hz / (freq_100[k] * mult)) * 100;
    endfunction

    // Scan from the top so the lowest matching index is kept
    function automatic int expected_note(input int p);
        int base;
        expected_note = -1;
        for (int k = n_notes - 1; k >= 0; k--) begin
            for (int j = 0; j < 3; j++) begin
                base = clk_hz / (freq_100[k] * (1 << j));
                if (p > 0 && p > base * win_low_pct && p < base * win_high_pct) begin
                    expected_note = k;
                end
            end
        end
    endfunction

    function automatic seg_t expected_seg(input int p);
        int idx;
        idx = expected_note(p);
        expected_seg = (idx < 0) ? seg_none : seg_table[idx];
    endfunction

    // --------------------------------------------------
    // Stimulus table

    task automatic add_step(input int kind, input int period, input bit press,
                            input game_state_t exp_state, input int exp_pos);
        steps[n_steps].kind      = kind;
        steps[n_steps].period    = period;
        steps[n_steps].press     = press;
        steps[n_steps].exp_state = exp_state;
        steps[n_steps].exp_pos   = exp_pos;
        n_steps++;
    endtask

    task automatic build_table();
        // Every note in the 4x window and C an octave lower
        for (int k = 0; k < n_notes; k++) begin
            add_step(step_tone, centre_period(k, 4), 1'b0, idle, 0);
        end
        add_step(step_tone, centre_period(0, 2), 1'b0, idle, 0);
        // Off every window, then A an octave lower and silence
        add_step(step_tone, off_window, 1'b0, idle, 0);
        add_step(step_tone, centre_period(9, 2), 1'b0, idle, 0);
        add_step(step_silence, 0, 1'b0, idle, 0);
        // Full song ending in a win
        add_step(step_start, 0, 1'b1, playing, 0);
        for (int k = 0; k < song_len; k++) begin
            if (k > 0) begin
                add_step(step_silence, 0, 1'b0, playing, k);
            end
            if (k == song_len - 1) begin
                add_step(step_tone, centre_period(int'(song[k]), 4), 1'b0, win, k);
            end else begin
                add_step(step_tone, centre_period(int'(song[k]), 4), 1'b0, playing, k + 1);
            end
        end
        add_step(step_silence, 0, 1'b0, win, song_len - 1);
        add_step(step_start, 0, 1'b1, idle, 0);
        // Two good notes, then A where D is due
        add_step(step_start, 0, 1'b1, playing, 0);
        add_step(step_tone, centre_period(int'(song[0]), 4), 1'b0, playing, 1);
        add_step(step_silence, 0, 1'b0, playing, 1);
        add_step(step_tone, centre_period(int'(song[1]), 4), 1'b0, playing, 2);
        add_step(step_silence, 0, 1'b0, playing, 2);
        add_step(step_tone, centre_period(9, 4), 1'b0, fail, 2);
        add_step(step_silence, 0, 1'b0, fail, 2);
        add_step(step_start, 0, 1'b1, idle, 0);
        // Abort mid-song, then a note while idle
        add_step(step_start, 0, 1'b1, playing, 0);
        add_step(step_tone, centre_period(int'(song[0]), 4), 1'b0, playing, 1);
        add_step(step_silence, 0, 1'b0, playing, 1);
        add_step(step_start, 0, 1'b1, idle, 0);
        add_step(step_tone, centre_period(int'(song[1]), 4), 1'b0, idle, 0);
    endtask

    function automatic int step_length(input int idx);
        step_length = settle_len + 1;
        if (steps[idx].press) begin
            step_length += press_len + press_gap + 1;
        end
        if (steps[idx].kind == step_tone) begin
            step_length += tone_periods * (steps[idx].period + max_jitter) + 1;
        end else if (steps[idx].kind == step_silence) begin
            step_length += silence_len;
        end
    endfunction

    // --------------------------------------------------
    // Drivers

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic press_start();
        @(posedge clk);
        start <= 1'b1;
        wait_cycles(press_len);
        start <= 1'b0;
        wait_cycles(press_gap);
    endtask

    // Square wave, high half first, ends back at the high level
    task automatic play_tone(input int period_cycles);
        int half;
        half = period_cycles / 2;
        for (int p = 0; p < tone_periods; p++) begin
            for (int i = 0; i < period_cycles; i++) begin
                @(posedge clk);
                mic <= (i < half) ? mic_high : mic_low;
            end
        end
        @(posedge clk);
        mic <= mic_high;
    endtask

    task automatic hold_silence();
        @(posedge clk);
        mic <= mic_high;
        wait_cycles(silence_len - 1);
    endtask

    // --------------------------------------------------
    // Checks

    task automatic check_outputs(input int idx, input game_state_t exp_state,
                                 input int exp_pos, input seg_t exp_seg);
        checks += 3;
        assert (game_state == exp_state) else begin
            errors++;
            $display("[FAIL] %0t step %0d game_state: got %s expected %s",
                     $time, idx, game_state.name(), exp_state.name());
        end
        assert (song_pos == w_song_pos'(exp_pos)) else begin
            errors++;
            $display("[FAIL] %0t step %0d song_pos: got %0d expected %0d",
                     $time, idx, song_pos, exp_pos);
        end
        assert (abcdefgh == exp_seg) else begin
            errors++;
            $display("[FAIL] %0t step %0d abcdefgh: got %b expected %b",
                     $time, idx, abcdefgh, exp_seg);
        end
    endtask

    task automatic run_step(input int idx);
        int   played;
        seg_t exp_seg;
        exp_seg = seg_none;
        if (steps[idx].press) begin
            press_start();
        end
        if (steps[idx].kind == step_tone) begin
            played = steps[idx].period + int'($urandom % (max_jitter + 1));
            play_tone(played);
            // Counter restarts at 0, so a wave of P cycles reads P - 1
            exp_seg = expected_seg(played - 1);
        end else if (steps[idx].kind == step_silence) begin
            hold_silence();
        end
        wait_cycles(settle_len);
        @(negedge clk);
        check_outputs(idx, steps[idx].exp_state, steps[idx].exp_pos, exp_seg);
    endtask

    // --------------------------------------------------
    // Main sequence

    initial begin : main_seq
        int total;
        rst   = 1'b1;
        start = 1'b0;
        mic   = mic_high;
        void'($urandom(92));
        build_table();
        total = reset_cycles + 2;
        for (int i = 0; i < n_steps; i++) begin
            total += step_length(i);
        end
        cycle_limit = total + total / 5;

        wait_cycles(reset_cycles);
        rst <= 1'b0;
        @(negedge clk);
        checks += 4;
        assert (game_state == idle) else begin
            errors++;
            $display("[FAIL] %0t game_state after reset: got %s expected idle",
                     $time, game_state.name());
        end
        assert (song_pos == '0) else begin
            errors++;
            $display("[FAIL] %0t song_pos after reset: got %0d expected 0",
                     $time, song_pos);
        end
        assert (abcdefgh == '0) else begin
            errors++;
            $display("[FAIL] %0t abcdefgh after reset: got %b expected %b",
                     $time, abcdefgh, 8'b0);
        end
        assert (digit == w_digit'(1)) else begin
            errors++;
            $display("[FAIL] %0t digit: got %b expected %b", $time, digit, w_digit'(1));
        end

        for (int i = 0; i < n_steps; i++) begin
            run_step(i);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Cycle watchdog
    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: no result after %0d cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
